// File: hw/median_pkg.sv
//------------------------------------------------------------
// window geometry, default widths and pipeline latencies for
// the 5x5 median filter, referenced by scoped names
//------------------------------------------------------------
`default_nettype none

package median_pkg;

    // window shape
    parameter int KERNEL_DIM  = 5;
    parameter int KERNEL_SIZE = KERNEL_DIM * KERNEL_DIM;

    // median in sorted order, also the centre tap in raster order
    parameter int MEDIAN_TAP = KERNEL_SIZE / 2;

    // batcher network for 32 inputs truncated to 25
    parameter int SORT_STAGES = 15;

    // cycles from input pixel to registered window
    parameter int WINDOW_LATENCY = 1;

    // input to output of the whole filter
    parameter int FILTER_LATENCY = WINDOW_LATENCY + SORT_STAGES;

    // defaults for the top level
    parameter int DEFAULT_PIXEL_WIDTH   = 12;
    parameter int DEFAULT_LINE_SIZE_MAX = 1024;

endpackage

`default_nettype wire

// File: hw/line_buffer.sv
//------------------------------------------------------------
// one video line of pixel delay, read and written at the
// same column address in the same cycle
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module line_buffer #(
    parameter int PIXEL_WIDTH   = 12,
    parameter int LINE_SIZE_MAX = 1024
)(
    input  logic                             clk,
    input  logic                             wr_en_i,
    input  logic [$clog2(LINE_SIZE_MAX)-1:0] addr_i,
    input  logic [PIXEL_WIDTH-1:0]           pix_i,
    output logic [PIXEL_WIDTH-1:0]           pix_o
);

    logic [PIXEL_WIDTH-1:0] mem [0:LINE_SIZE_MAX-1];

    // old content comes out before the write lands
    assign pix_o = mem[addr_i];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[addr_i] <= pix_i;
        end
    end

endmodule

`default_nettype wire

// File: hw/delay_pipe.sv
//------------------------------------------------------------
// fixed depth shift register for any payload type, cleared
// on reset only when CLEAR_ON_RESET is set
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module delay_pipe #(
    parameter type payload_t      = logic,
    parameter int  DEPTH          = 1,
    parameter bit  CLEAR_ON_RESET = 1'b1
)(
    input  logic     clk,
    input  logic     rst_i,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t pipe_q [0:DEPTH-1];

    always_ff @(posedge clk) begin
        if (CLEAR_ON_RESET && rst_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe_q[i] <= '0;
            end
        end else begin
            pipe_q[0] <= d_i;
            for (int i = 1; i < DEPTH; i++) begin
                pipe_q[i] <= pipe_q[i-1];
            end
        end
    end

    assign q_o = pipe_q[DEPTH-1];

endmodule

`default_nettype wire

// File: hw/window_5x5.sv
//------------------------------------------------------------
// builds the 5x5 neighbourhood of a raster stream from four
// chained line buffers; window and flags are registered
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module window_5x5 #(
    parameter int PIXEL_WIDTH   = 12,
    parameter int LINE_SIZE_MAX = 1024
)(
    input  logic                                            clk,
    input  logic                                            rst_i,
    input  logic [PIXEL_WIDTH-1:0]                          pix_i,
    input  logic                                            de_i,
    input  logic                                            vs_i,
    output logic [median_pkg::KERNEL_SIZE*PIXEL_WIDTH-1:0] win_o,
    output logic                                            win_de_o,
    output logic                                            win_vs_o
);

    localparam int DIM        = median_pkg::KERNEL_DIM;
    localparam int ADDR_W     = $clog2(LINE_SIZE_MAX);
    localparam int LINE_CNT_W = $clog2(DIM);

    logic [ADDR_W-1:0]      col_q;
    logic [LINE_CNT_W-1:0]  line_cnt_q;
    logic                   de_q;
    logic                   line_end;
    logic                   lines_full;
    logic                   win_valid;

    // tap_src[n] is the pixel of the same column n lines back
    logic [PIXEL_WIDTH-1:0] tap_src [0:DIM-1];
    logic [PIXEL_WIDTH-1:0] win_q   [0:median_pkg::KERNEL_SIZE-1];

    //------------------------------------------------------------
    // column and line counters
    //------------------------------------------------------------
    assign line_end   = de_q && !de_i;
    // line count saturates once enough lines are stored
    assign lines_full = (line_cnt_q == LINE_CNT_W'(DIM - 1));
    assign win_valid  = de_i && lines_full && (col_q >= ADDR_W'(DIM - 1));

    always_ff @(posedge clk) begin
        if (rst_i) begin
            col_q      <= '0;
            line_cnt_q <= '0;
            de_q       <= 1'b0;
            win_de_o   <= 1'b0;
            win_vs_o   <= 1'b0;
        end else begin
            de_q     <= de_i;
            win_de_o <= win_valid;
            win_vs_o <= vs_i;

            if (de_i) begin
                col_q <= col_q + 1'b1;
            end else begin
                col_q <= '0;
            end

            if (vs_i) begin
                line_cnt_q <= '0;
            end else if (line_end && !lines_full) begin
                line_cnt_q <= line_cnt_q + 1'b1;
            end
        end
    end

    //------------------------------------------------------------
    // line buffer chain
    //------------------------------------------------------------
    assign tap_src[0] = pix_i;

    for (genvar n = 0; n < DIM - 1; n++) begin : g_line
        line_buffer #(
            .PIXEL_WIDTH   (PIXEL_WIDTH),
            .LINE_SIZE_MAX (LINE_SIZE_MAX)
        ) u_line_buffer (
            .clk     (clk),
            .wr_en_i (de_i),
            .addr_i  (col_q),
            .pix_i   (tap_src[n]),
            .pix_o   (tap_src[n+1])
        );
    end

    //------------------------------------------------------------
    // window shift registers
    //------------------------------------------------------------
    // row 0 is the oldest line, column 4 the newest pixel
    always_ff @(posedge clk) begin
        if (de_i) begin
            for (int r = 0; r < DIM; r++) begin
                for (int c = 0; c < DIM - 1; c++) begin
                    win_q[r*DIM + c] <= win_q[r*DIM + c + 1];
                end
                win_q[r*DIM + DIM - 1] <= tap_src[DIM - 1 - r];
            end
        end
    end

    for (genvar t = 0; t < median_pkg::KERNEL_SIZE; t++) begin : g_flat
        assign win_o[t*PIXEL_WIDTH +: PIXEL_WIDTH] = win_q[t];
    end

endmodule

`default_nettype wire

// File: hw/median_sort_net.sv
//------------------------------------------------------------
// pipelined batcher sorting network over the 25 window taps;
// outputs the median with the centre pixel and flags aligned
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module median_sort_net #(
    parameter int PIXEL_WIDTH = 12
)(
    input  logic                                            clk,
    input  logic                                            rst_i,
    input  logic [median_pkg::KERNEL_SIZE*PIXEL_WIDTH-1:0] win_i,
    input  logic                                            win_de_i,
    input  logic                                            win_vs_i,
    output logic [PIXEL_WIDTH-1:0]                          median_o,
    output logic [PIXEL_WIDTH-1:0]                          centre_o,
    output logic                                            de_o,
    output logic                                            vs_o
);

    localparam int KS     = median_pkg::KERNEL_SIZE;
    localparam int STAGES = median_pkg::SORT_STAGES;

    logic [PIXEL_WIDTH-1:0] stage_in  [0:STAGES-1][0:KS-1];
    logic [PIXEL_WIDTH-1:0] stage_nxt [0:STAGES-1][0:KS-1];
    logic [PIXEL_WIDTH-1:0] stage_q   [0:STAGES-1][0:KS-1];
    logic [1:0]             flags_q;

    //------------------------------------------------------------
    // network description
    //------------------------------------------------------------
    // odd-even merge sort for a power of two, with pairs beyond
    // the last element dropped; returns idx when it is unpaired
    function automatic int partner(input int stage, input int idx);
        int res;
        int s;
        int p;
        int k;
        int j;
        int i;
        int lim;
        res = idx;
        s   = 0;
        for (p = 1; p < KS; p = p * 2) begin
            for (k = p; k >= 1; k = k / 2) begin
                if (s == stage) begin
                    for (j = k % p; j <= KS - 1 - k; j = j + 2 * k) begin
                        lim = (k - 1 < KS - j - k - 1) ? k - 1 : KS - j - k - 1;
                        for (i = 0; i <= lim; i++) begin
                            if ((i + j) / (2 * p) == (i + j + k) / (2 * p)) begin
                                if (i + j == idx) begin
                                    res = i + j + k;
                                end
                                if (i + j + k == idx) begin
                                    res = i + j;
                                end
                            end
                        end
                    end
                end
                s++;
            end
        end
        return res;
    endfunction

    // lower index of a pair keeps the smaller value
    function automatic logic [PIXEL_WIDTH-1:0] compare_exchange(
        input logic [PIXEL_WIDTH-1:0] own,
        input logic [PIXEL_WIDTH-1:0] other,
        input int                     self_idx,
        input int                     part_idx
    );
        if (part_idx == self_idx) begin
            return own;
        end else if (part_idx > self_idx) begin
            return (own > other) ? other : own;
        end else begin
            return (own > other) ? own : other;
        end
    endfunction

    //------------------------------------------------------------
    // sorting stages
    //------------------------------------------------------------
    for (genvar s = 0; s < STAGES; s++) begin : g_stage
        for (genvar e = 0; e < KS; e++) begin : g_elem
            localparam int PART = partner(s, e);

            if (s == 0) begin : g_first
                assign stage_in[s][e] = win_i[e*PIXEL_WIDTH +: PIXEL_WIDTH];
            end else begin : g_next
                assign stage_in[s][e] = stage_q[s-1][e];
            end

            assign stage_nxt[s][e] = compare_exchange(stage_in[s][e],
                                                      stage_in[s][PART], e, PART);
        end
    end

    always_ff @(posedge clk) begin
        stage_q <= stage_nxt;
    end

    assign median_o = stage_q[STAGES-1][median_pkg::MEDIAN_TAP];

    //------------------------------------------------------------
    // side channels, same depth as the network
    //------------------------------------------------------------
    delay_pipe #(
        .payload_t      (logic [PIXEL_WIDTH-1:0]),
        .DEPTH          (STAGES),
        .CLEAR_ON_RESET (1'b0)
    ) u_centre_pipe (
        .clk   (clk),
        .rst_i (rst_i),
        .d_i   (win_i[median_pkg::MEDIAN_TAP*PIXEL_WIDTH +: PIXEL_WIDTH]),
        .q_o   (centre_o)
    );

    // bit 1 frame start, bit 0 data enable
    delay_pipe #(
        .payload_t      (logic [1:0]),
        .DEPTH          (STAGES),
        .CLEAR_ON_RESET (1'b1)
    ) u_flag_pipe (
        .clk   (clk),
        .rst_i (rst_i),
        .d_i   ({win_vs_i, win_de_i}),
        .q_o   (flags_q)
    );

    assign de_o = flags_q[0];
    assign vs_o = flags_q[1];

endmodule

`default_nettype wire

// File: hw/median_filter_5x5.sv
//------------------------------------------------------------
// 5x5 median filter top level; an X by Y input frame gives
// an (X-4) by (Y-4) output frame FILTER_LATENCY cycles later
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module median_filter_5x5 #(
    parameter int PIXEL_WIDTH   = median_pkg::DEFAULT_PIXEL_WIDTH,
    parameter int LINE_SIZE_MAX = median_pkg::DEFAULT_LINE_SIZE_MAX
)(
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic [PIXEL_WIDTH-1:0] pix_i,
    input  logic                   de_i,
    input  logic                   vs_i,
    output logic [PIXEL_WIDTH-1:0] median_o,
    output logic [PIXEL_WIDTH-1:0] centre_o,
    output logic                   de_o,
    output logic                   vs_o
);

    logic [median_pkg::KERNEL_SIZE*PIXEL_WIDTH-1:0] win;
    logic                                            win_de;
    logic                                            win_vs;

    window_5x5 #(
        .PIXEL_WIDTH   (PIXEL_WIDTH),
        .LINE_SIZE_MAX (LINE_SIZE_MAX)
    ) u_window (
        .clk      (clk),
        .rst_i    (rst_i),
        .pix_i    (pix_i),
        .de_i     (de_i),
        .vs_i     (vs_i),
        .win_o    (win),
        .win_de_o (win_de),
        .win_vs_o (win_vs)
    );

    median_sort_net #(
        .PIXEL_WIDTH (PIXEL_WIDTH)
    ) u_sort_net (
        .clk      (clk),
        .rst_i    (rst_i),
        .win_i    (win),
        .win_de_i (win_de),
        .win_vs_i (win_vs),
        .median_o (median_o),
        .centre_o (centre_o),
        .de_o     (de_o),
        .vs_o     (vs_o)
    );

endmodule

`default_nettype wire

// File: dv/median_filter_props.sv
//------------------------------------------------------------
// concurrent checks on the output flags of the filter top
// level, attached to every median_filter_5x5 by bind
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module median_filter_props (
    input logic clk,
    input logic rst_i,
    input logic vs_i,
    input logic de_o,
    input logic vs_o
);

    localparam int LAT = median_pkg::FILTER_LATENCY;

    logic [LAT-1:0] vs_hist;
    int unsigned    fail_cnt = 0;

    // frame start as it should leave the filter
    always_ff @(posedge clk) begin
        if (rst_i) begin
            vs_hist <= '0;
        end else begin
            vs_hist <= {vs_hist[LAT-2:0], vs_i};
        end
    end

    flags_low_in_reset: assert property (@(posedge clk) $past(rst_i) |-> !de_o && !vs_o)
        else begin
            fail_cnt++;
            $error("de_o or vs_o high after a reset cycle");
        end

    vs_delay: assert property (@(posedge clk) disable iff (rst_i) vs_o == vs_hist[LAT-1])
        else begin
            fail_cnt++;
            $error("vs_o does not follow vs_i by the filter latency");
        end

    de_vs_exclusive: assert property (@(posedge clk) disable iff (rst_i) !(de_o && vs_o))
        else begin
            fail_cnt++;
            $error("de_o and vs_o high together");
        end

endmodule

bind median_filter_5x5 median_filter_props u_props (
    .clk   (clk),
    .rst_i (rst_i),
    .vs_i  (vs_i),
    .de_o  (de_o),
    .vs_o  (vs_o)
);

`default_nettype wire

// File: dv/median_filter_tb.sv
//------------------------------------------------------------
// directed tests for the 5x5 median filter; each window is
// sorted from a local copy of the frame as the reference
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module median_filter_tb;

    localparam int PIX_W    = 8;
    localparam int LINE_GAP = 3;
    localparam int LATENCY  = median_pkg::FILTER_LATENCY;
    localparam int TIMEOUT  = 2000;

    logic             clk = 1'b0;
    logic             rst_i;
    logic [PIX_W-1:0] pix_i;
    logic             de_i;
    logic             vs_i;
    logic [PIX_W-1:0] median_o;
    logic [PIX_W-1:0] centre_o;
    logic             de_o;
    logic             vs_o;

    int frame_pix [0:15][0:15];
    int exp_median[$];
    int exp_centre[$];
    int got_median[$];
    int got_centre[$];
    int frame_out_cnt[$];
    int vs_in_cycle[$];
    int vs_out_cycle[$];
    int cycle_cnt = 0;
    int error_cnt = 0;
    int test_cnt  = 0;

    median_filter_5x5 #(
        .PIXEL_WIDTH   (PIX_W),
        .LINE_SIZE_MAX (64)
    ) DUT (
        .clk      (clk),
        .rst_i    (rst_i),
        .pix_i    (pix_i),
        .de_i     (de_i),
        .vs_i     (vs_i),
        .median_o (median_o),
        .centre_o (centre_o),
        .de_o     (de_o),
        .vs_o     (vs_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // output monitor on the falling edge
    always @(negedge clk) begin
        if (vs_o === 1'b1) begin
            vs_out_cycle.push_back(cycle_cnt);
            frame_out_cnt.push_back(0);
        end
        if (de_o === 1'b1) begin
            got_median.push_back(int'(median_o));
            got_centre.push_back(int'(centre_o));
            if (frame_out_cnt.size() > 0) begin
                frame_out_cnt[frame_out_cnt.size()-1]++;
            end
        end
    end

    //------------------------------------------------------------
    // helpers
    //------------------------------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("FAILED at %0t ns: %s got %0d expected %0d", $time, sig, got, want);
        error_cnt++;
    endtask

    task automatic report_problem(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        error_cnt++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_cnt++;
        $display("test %-14s %0d errors", name, error_cnt - errs_before);
    endtask

    task automatic clear_queues();
        exp_median.delete();
        exp_centre.delete();
        got_median.delete();
        got_centre.delete();
        frame_out_cnt.delete();
        vs_in_cycle.delete();
        vs_out_cycle.delete();
    endtask

    // a negative value gives random pixels
    task automatic fill_frame(input int width, input int height, input int value);
        for (int y = 0; y < height; y++) begin
            for (int x = 0; x < width; x++) begin
                frame_pix[y][x] = (value < 0) ? int'($urandom_range(0, 255)) : value;
            end
        end
    endtask

    // insertion sorted window ending at (y, x)
    function automatic int window_median(input int y, input int x);
        int vals [0:24];
        int tmp;
        int j;
        for (int r = 0; r < 5; r++) begin
            for (int c = 0; c < 5; c++) begin
                vals[r*5 + c] = frame_pix[y-4+r][x-4+c];
            end
        end
        for (int i = 1; i < 25; i++) begin
            tmp = vals[i];
            j   = i - 1;
            while (j >= 0 && vals[j] > tmp) begin
                vals[j+1] = vals[j];
                j--;
            end
            vals[j+1] = tmp;
        end
        return vals[12];
    endfunction

    task automatic queue_expected(input int width, input int height);
        for (int y = 4; y < height; y++) begin
            for (int x = 4; x < width; x++) begin
                exp_median.push_back(window_median(y, x));
                exp_centre.push_back(frame_pix[y-2][x-2]);
            end
        end
    endtask

    task automatic send_frame(input int width, input int height);
        vs_i = 1'b1;
        vs_in_cycle.push_back(cycle_cnt);
        next_cycle();
        vs_i = 1'b0;
        repeat (LINE_GAP) next_cycle();
        for (int y = 0; y < height; y++) begin
            for (int x = 0; x < width; x++) begin
                pix_i = PIX_W'(frame_pix[y][x]);
                de_i  = 1'b1;
                next_cycle();
            end
            de_i  = 1'b0;
            pix_i = '0;
            repeat (LINE_GAP) next_cycle();
        end
    endtask

    task automatic wait_for_outputs(input int count);
        int waited;
        int quiet;
        waited = 0;
        while (got_median.size() < count && waited < TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (got_median.size() < count) begin
            report_problem($sformatf("timeout with %0d of %0d outputs seen",
                                     got_median.size(), count));
        end
        // pipeline runs empty so that extra outputs get counted
        quiet  = 0;
        waited = 0;
        while (quiet < LATENCY + 2 && waited < TIMEOUT) begin
            next_cycle();
            waited++;
            quiet = (de_o === 1'b1) ? 0 : quiet + 1;
        end
        if (quiet < LATENCY + 2) begin
            report_problem("timeout waiting for de_o to stay low");
        end
    endtask

    task automatic compare_queues(input string sig, input int seen[$], input int want[$]);
        if (seen.size() != want.size()) begin
            report_mismatch({sig, " count"}, seen.size(), want.size());
        end
        for (int i = 0; i < seen.size() && i < want.size(); i++) begin
            if (seen[i] != want[i]) begin
                report_mismatch($sformatf("%s[%0d]", sig, i), seen[i], want[i]);
            end
        end
    endtask

    //------------------------------------------------------------
    // tests
    //------------------------------------------------------------
    task automatic test_reset();
        int errs;
        errs  = error_cnt;
        rst_i = 1'b1;
        for (int i = 0; i < 14; i++) begin
            next_cycle();
            if (i == 3) begin
                rst_i = 1'b0;
            end
            if (de_o !== 1'b0) begin
                report_mismatch("de_o", 32'(de_o), 0);
            end
            if (vs_o !== 1'b0) begin
                report_mismatch("vs_o", 32'(vs_o), 0);
            end
        end
        finish_test("reset", errs);
    endtask

    task automatic test_constant();
        int errs;
        errs = error_cnt;
        clear_queues();
        fill_frame(10, 8, 90);
        queue_expected(10, 8);
        send_frame(10, 8);
        wait_for_outputs(exp_median.size());
        compare_queues("median_o", got_median, exp_median);
        compare_queues("centre_o", got_centre, exp_centre);
        finish_test("constant", errs);
    endtask

    task automatic test_random_median();
        int errs;
        errs = error_cnt;
        clear_queues();
        fill_frame(12, 9, -1);
        queue_expected(12, 9);
        send_frame(12, 9);
        wait_for_outputs(exp_median.size());
        compare_queues("median_o", got_median, exp_median);
        finish_test("random_median", errs);
    endtask

    // reuses the frame collected by test_random_median
    task automatic test_centre_pixel();
        int errs;
        errs = error_cnt;
        compare_queues("centre_o", got_centre, exp_centre);
        finish_test("centre_pixel", errs);
    endtask

    task automatic test_new_frame();
        int errs;
        errs = error_cnt;
        clear_queues();
        fill_frame(10, 6, -1);
        queue_expected(10, 6);
        send_frame(10, 6);
        fill_frame(9, 9, -1);
        queue_expected(9, 9);
        send_frame(9, 9);
        wait_for_outputs(exp_median.size());
        compare_queues("median_o", got_median, exp_median);
        if (frame_out_cnt.size() != 2) begin
            report_problem($sformatf("saw %0d output frames instead of 2", frame_out_cnt.size()));
        end else begin
            if (frame_out_cnt[0] != (10 - 4) * (6 - 4)) begin
                report_mismatch("frame 0 de_o count", frame_out_cnt[0], (10 - 4) * (6 - 4));
            end
            if (frame_out_cnt[1] != (9 - 4) * (9 - 4)) begin
                report_mismatch("frame 1 de_o count", frame_out_cnt[1], (9 - 4) * (9 - 4));
            end
        end
        if (vs_out_cycle.size() != vs_in_cycle.size()) begin
            report_problem("number of vs_o pulses differs from vs_i pulses");
        end else begin
            for (int i = 0; i < vs_in_cycle.size(); i++) begin
                if (vs_out_cycle[i] - vs_in_cycle[i] != LATENCY) begin
                    report_mismatch("vs_o delay", vs_out_cycle[i] - vs_in_cycle[i], LATENCY);
                end
            end
        end
        finish_test("new_frame", errs);
    endtask

    initial begin
        rst_i = 1'b1;
        pix_i = '0;
        de_i  = 1'b0;
        vs_i  = 1'b0;
        void'($urandom(80600));
        test_reset();
        test_constant();
        test_random_median();
        test_centre_pixel();
        test_new_frame();
        error_cnt += int'(DUT.u_props.fail_cnt);
        $display("tests run %0d, errors %0d", test_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hw/median_pkg.sv
hw/line_buffer.sv
hw/delay_pipe.sv
hw/window_5x5.sv
hw/median_sort_net.sv
hw/median_filter_5x5.sv
dv/median_filter_props.sv
dv/median_filter_tb.sv

// File: Makefile
# Verilator build and run of the 5x5 median filter testbench

VERILATOR ?= verilator
TOP       ?= median_filter_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(wildcard hw/*.sv dv/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) filelist.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f filelist.f -Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	-$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "FAIL: no result in log"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
